// File: bench/exec_cluster_ref.svh
`ifndef EXEC_CLUSTER_REF_SVH
`define EXEC_CLUSTER_REF_SVH

// literal is zero extended to the full width
function automatic logic [DATA_WIDTH-1:0] ref_operand_b(input issue_packet_t pkt);
  logic [DATA_WIDTH-1:0] b;
  b = pkt.opb_reg;
  if (pkt.opb_sel == OPB_IS_LIT) begin
    b = DATA_WIDTH'(pkt.lit);
  end
  return b;
endfunction

function automatic logic [DATA_WIDTH-1:0] ref_result(input issue_packet_t pkt);
  logic        [DATA_WIDTH-1:0] a;
  logic        [DATA_WIDTH-1:0] b;
  logic signed [DATA_WIDTH-1:0] sa;
  logic signed [DATA_WIDTH-1:0] sb;
  logic        [SHIFT_BITS-1:0] sh;
  logic        [DATA_WIDTH-1:0] r;
  a  = pkt.opa;
  b  = ref_operand_b(pkt);
  sa = a;
  sb = b;
  sh = b[SHIFT_BITS-1:0];
  r  = '0;
  case (pkt.func)
    ALU_ADDQ:   r = a + b;
    ALU_SUBQ:   r = a - b;
    ALU_AND:    r = a & b;
    ALU_BIC:    r = a & ~b;
    ALU_BIS:    r = a | b;
    ALU_ORNOT:  r = a | ~b;
    ALU_XOR:    r = a ^ b;
    ALU_EQV:    r = ~(a ^ b);
    ALU_SRL:    r = a >> sh;
    ALU_SLL:    r = a << sh;
    ALU_SRA:    r = (a >> sh) | (a[DATA_WIDTH-1] ? ~({DATA_WIDTH{1'b1}} >> sh) : '0);
    ALU_CMPULT: r[0] = a < b;
    ALU_CMPEQ:  r[0] = a == b;
    ALU_CMPULE: r[0] = a <= b;
    ALU_CMPLT:  r[0] = sa < sb;
    ALU_CMPLE:  r[0] = sa <= sb;
    ALU_MULQ:   r = a * b;  // low half of the product
    default:    r = '0;
  endcase
  return r;
endfunction

`endif

// File: bench/exec_cluster_tb.sv
`timescale 1ns/1ps

module exec_cluster_tb import fu_pkg::*; ();

  typedef struct packed {
    alu_func_t             func;
    logic [DATA_WIDTH-1:0] opa;
    opb_sel_t              opb_sel;
    logic [DATA_WIDTH-1:0] opb_reg;
    logic [LIT_WIDTH-1:0]  lit;
    logic [DATA_WIDTH-1:0] expected;
  } vector_t;

  logic          clock;
  logic          reset;
  logic          issue_valid;
  issue_packet_t issue;
  logic          cdb_valid;
  fu_result_t    cdb;

  vector_t                      vectors [27];
  logic [31:0]                  lcg_state;
  logic                         scoreboard_on;
  logic [2**ROB_TAG_WIDTH-1:0]  pending;  // one bit per rob slot
  logic [DATA_WIDTH-1:0]        expected_value [2**ROB_TAG_WIDTH];
  fu_result_t                   arrivals [$];

  `include "exec_cluster_ref.svh"

  exec_cluster i_exec_cluster (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue       (issue),
    .cdb_valid   (cdb_valid),
    .cdb         (cdb)
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_valid(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      abort_run($sformatf("** Error at %0t: %s, cdb_valid %b expected %b",
                          $time, what, actual, expected));
    end
  endtask

  task automatic check_result(input fu_result_t actual, input fu_result_t expected,
                              input string what);
    if (actual !== expected) begin
      abort_run($sformatf("** Error at %0t: %s, got tag %0d value %h, expected tag %0d value %h",
                          $time, what, actual.rob_tag, actual.result,
                          expected.rob_tag, expected.result));
    end
  endtask

  function automatic fu_result_t make_result(input rob_tag_t tag,
                                             input logic [DATA_WIDTH-1:0] value);
    fu_result_t res;
    res.rob_tag = tag;
    res.result  = value;
    return res;
  endfunction

  function automatic issue_packet_t make_packet(input vector_t vec, input rob_tag_t tag);
    issue_packet_t pkt;
    pkt.func    = vec.func;
    pkt.opa     = vec.opa;
    pkt.opb_sel = vec.opb_sel;
    pkt.opb_reg = vec.opb_reg;
    pkt.lit     = vec.lit;
    pkt.rob_tag = tag;
    return pkt;
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic issue_packet_t random_packet(input rob_tag_t tag);
    issue_packet_t pkt;
    logic [31:0]   r;
    r           = lcg_next();
    pkt.func    = alu_func_t'((r >> 16) % 17);
    pkt.opa     = {lcg_next(), lcg_next()};
    pkt.opb_reg = {lcg_next(), lcg_next()};
    pkt.opb_sel = r[5] ? OPB_IS_LIT : OPB_IS_REGB;
    pkt.lit     = r[31:24];
    if (r[7:6] == 2'b00) begin
      pkt.opb_reg = pkt.opa;  // lets equality compares hit
    end
    pkt.rob_tag = tag;
    return pkt;
  endfunction

  function automatic void load_vectors();
    vectors[0]  = '{ALU_ADDQ,   64'd5,      OPB_IS_REGB, 64'd7,      8'd0,  64'd12};
    vectors[1]  = '{ALU_SUBQ,   64'd3,      OPB_IS_LIT,  64'd0,      8'd5,  -64'd2};
    vectors[2]  = '{ALU_AND,    64'hF0F0,   OPB_IS_REGB, 64'hFF00,   8'd0,  64'hF000};
    vectors[3]  = '{ALU_BIC,    64'hFFFF,   OPB_IS_LIT,  64'd0,      8'h0F, 64'hFFF0};
    vectors[4]  = '{ALU_BIS,    64'hF000,   OPB_IS_REGB, 64'h000F,   8'd0,  64'hF00F};
    vectors[5]  = '{ALU_ORNOT,  64'd0,      OPB_IS_REGB, ~64'hFF,    8'd0,  64'hFF};
    vectors[6]  = '{ALU_XOR,    64'hFF,     OPB_IS_LIT,  64'd0,      8'h0F, 64'hF0};
    vectors[7]  = '{ALU_EQV,    64'hFF,     OPB_IS_REGB, 64'hFF,     8'd0,  -64'd1};
    vectors[8]  = '{ALU_SRL,    64'h8000_0000_0000_0000, OPB_IS_LIT, 64'd0, 8'd63, 64'd1};
    vectors[9]  = '{ALU_SRL,    64'h1234,   OPB_IS_LIT,  64'd0,      8'd0,  64'h1234};
    vectors[10] = '{ALU_SLL,    64'd1,      OPB_IS_LIT,  64'd0,      8'd63,
                    64'h8000_0000_0000_0000};
    vectors[11] = '{ALU_SLL,    64'h1234,   OPB_IS_REGB, 64'd0,      8'd0,  64'h1234};
    vectors[12] = '{ALU_SRA,    64'h8000_0000_0000_0000, OPB_IS_LIT, 64'd0, 8'd63, -64'd1};
    vectors[13] = '{ALU_SRA,    64'h8000_0000_0000_0000, OPB_IS_REGB, 64'd0, 8'd0,
                    64'h8000_0000_0000_0000};
    vectors[14] = '{ALU_CMPULT, 64'd1,      OPB_IS_REGB, -64'd1,     8'd0,  64'd1};
    vectors[15] = '{ALU_CMPEQ,  64'd42,     OPB_IS_LIT,  64'd0,      8'd42, 64'd1};
    vectors[16] = '{ALU_CMPULE, -64'd1,     OPB_IS_REGB, 64'd1,      8'd0,  64'd0};
    vectors[17] = '{ALU_CMPLT,  -64'd1,     OPB_IS_REGB, 64'd1,      8'd0,  64'd1};
    vectors[18] = '{ALU_CMPLT,  64'd5,      OPB_IS_REGB, -64'd3,     8'd0,  64'd0};
    vectors[19] = '{ALU_CMPLE,  64'd1,      OPB_IS_REGB, -64'd1,     8'd0,  64'd0};
    vectors[20] = '{ALU_CMPLE,  64'd7,      OPB_IS_LIT,  64'd0,      8'd7,  64'd1};
    vectors[21] = '{ALU_MULQ,   64'd6,      OPB_IS_REGB, 64'd7,      8'd0,  64'd42};
    vectors[22] = '{ALU_MULQ,   -64'd2,     OPB_IS_REGB, 64'd3,      8'd0,  -64'd6};
    vectors[23] = '{ALU_MULQ,   -64'd3,     OPB_IS_REGB, -64'd5,     8'd0,  64'd15};
    vectors[24] = '{ALU_MULQ,   64'h1_0000_0001, OPB_IS_LIT, 64'd0,  8'hFF, 64'hFF_0000_00FF};
    vectors[25] = '{ALU_MULQ,   64'h8000_0000_0000_0001, OPB_IS_REGB, 64'd2, 8'd0, 64'd2};
    vectors[26] = '{ALU_MULQ,   64'h1_0000_0000, OPB_IS_REGB, 64'h1_0000_0001, 8'd0,
                    64'h1_0000_0000};  // product overflows
  endfunction

  task automatic drive_issue(input issue_packet_t pkt);
    @(posedge clock);
    issue_valid <= 1'b1;
    issue       <= pkt;
  endtask

  task automatic drive_idle();
    @(posedge clock);
    issue_valid <= 1'b0;
  endtask

  task automatic expect_tag(input issue_packet_t pkt);
    if (pending[pkt.rob_tag]) begin
      abort_run($sformatf("tag %0d issued again before its result came back", pkt.rob_tag));
    end
    pending[pkt.rob_tag]        = 1'b1;
    expected_value[pkt.rob_tag] = ref_result(pkt);
  endtask

  task automatic wait_drained(input int limit);
    int cycles;
    cycles = 0;
    while (pending != '0) begin
      @(negedge clock);
      cycles++;
      if (cycles > limit) begin
        abort_run("timeout while waiting for outstanding results");
      end
    end
  endtask

  // every result must match an outstanding tag
  always @(negedge clock) begin
    if (scoreboard_on && cdb_valid) begin
      if (!pending[cdb.rob_tag]) begin
        abort_run($sformatf("extra result for tag %0d with nothing outstanding", cdb.rob_tag));
      end
      check_result(cdb, make_result(cdb.rob_tag, expected_value[cdb.rob_tag]), "scoreboard");
      pending[cdb.rob_tag] = 1'b0;
      arrivals.push_back(cdb);
    end
  end

  initial begin
    int            cyc;
    int            lat;
    int            next_mult;
    int            next_alu;
    issue_packet_t pkt;
    lcg_state     = 32'd40;
    scoreboard_on = 1'b0;
    pending       = '0;
    reset         = 1'b1;
    issue_valid   = 1'b0;
    issue         = '0;
    load_vectors();

    for (cyc = 0; cyc < 16; cyc++) begin
      @(posedge clock);
      if (cyc == 15) begin
        reset <= 1'b0;
      end
      @(negedge clock);
      check_valid(cdb_valid, 1'b0, "during reset");
    end
    for (cyc = 0; cyc < 20; cyc++) begin
      @(negedge clock);
      check_valid(cdb_valid, 1'b0, "idle after reset");
    end

    // directed ops issued one at a time
    foreach (vectors[v]) begin
      pkt = make_packet(vectors[v], rob_tag_t'(v));
      lat = (vectors[v].func == ALU_MULQ) ? NUM_MULT_STAGE + 1 : 2;
      drive_issue(pkt);
      for (cyc = 1; cyc <= lat; cyc++) begin
        drive_idle();
        @(negedge clock);
        check_valid(cdb_valid, cyc == lat, $sformatf("vector %0d cycle %0d", v, cyc));
      end
      check_result(cdb, make_result(pkt.rob_tag, vectors[v].expected),
                   $sformatf("vector %0d", v));
    end
    drive_idle();
    scoreboard_on = 1'b1;

    // four mulq then four alu ops back to back
    for (cyc = 0; cyc < 8; cyc++) begin
      pkt = random_packet(rob_tag_t'(8 + cyc));
      if (cyc < 4) begin
        pkt.func = ALU_MULQ;
      end else begin
        pkt.func = alu_func_t'(cyc - 4);
      end
      expect_tag(pkt);
      drive_issue(pkt);
    end
    drive_idle();
    wait_drained(40);
    if (arrivals.size() != 8) begin
      abort_run($sformatf("burst returned %0d results instead of 8", arrivals.size()));
    end
    next_mult = 8;
    next_alu  = 12;
    foreach (arrivals[a]) begin
      if (arrivals[a].rob_tag < rob_tag_t'(12)) begin
        check_result(arrivals[a], make_result(rob_tag_t'(next_mult), expected_value[next_mult]),
                     "multiplier order");
        next_mult++;
      end else begin
        check_result(arrivals[a], make_result(rob_tag_t'(next_alu), expected_value[next_alu]),
                     "alu order");
        next_alu++;
      end
    end

    // random stream of one op per cycle
    arrivals.delete();
    for (cyc = 0; cyc < 300; cyc++) begin
      pkt = random_packet(rob_tag_t'(cyc));
      expect_tag(pkt);
      drive_issue(pkt);
    end
    drive_idle();
    wait_drained(40);
    for (cyc = 0; cyc < 20; cyc++) begin
      @(negedge clock);  // any late strobe trips the scoreboard
    end
    if (arrivals.size() != 300) begin
      abort_run($sformatf("random stream returned %0d results instead of 300",
                          arrivals.size()));
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the execute cluster testbench with verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal \
  -f sources.f \
  --top-module exec_cluster_tb \
  --Mdir "$BUILD_DIR" \
  -o exec_cluster_sim

"./$BUILD_DIR/exec_cluster_sim" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "^STATUS: PASS$" "$LOG"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: sources.f
+incdir+bench
src/fu_pkg.sv
src/alu_unit.sv
src/mult_stage.sv
src/mult_pipeline.sv
src/result_merge.sv
src/exec_cluster.sv
bench/exec_cluster_tb.sv

// File: src/alu_unit.sv
`timescale 1ns/1ps

module alu_unit import fu_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  logic          issue_valid,
  input  issue_packet_t issue,
  output logic          alu_valid,
  output fu_result_t    alu_result
);

  logic [DATA_WIDTH-1:0] opa;
  logic [DATA_WIDTH-1:0] opb;
  logic [SHIFT_BITS-1:0] shamt;
  logic [DATA_WIDTH-1:0] alu_out;
  logic                  accept;

  // sign bit decides when the signs differ
  function automatic logic signed_lt(input logic [DATA_WIDTH-1:0] a,
                                     input logic [DATA_WIDTH-1:0] b);
    logic lt;
    if (a[DATA_WIDTH-1] == b[DATA_WIDTH-1]) begin
      lt = (a < b);
    end else begin
      lt = a[DATA_WIDTH-1];
    end
    return lt;
  endfunction

  assign opa    = issue.opa;
  assign opb    = operand_b(issue);
  assign shamt  = opb[SHIFT_BITS-1:0];
  assign accept = issue_valid && (issue.func != ALU_MULQ);

  always_comb begin
    case (issue.func)
      ALU_ADDQ:   alu_out = opa + opb;
      ALU_SUBQ:   alu_out = opa - opb;
      ALU_AND:    alu_out = opa & opb;
      ALU_BIC:    alu_out = opa & ~opb;
      ALU_BIS:    alu_out = opa | opb;
      ALU_ORNOT:  alu_out = opa | ~opb;
      ALU_XOR:    alu_out = opa ^ opb;
      ALU_EQV:    alu_out = opa ^ ~opb;
      ALU_SRL:    alu_out = opa >> shamt;
      ALU_SLL:    alu_out = opa << shamt;
      ALU_SRA:    alu_out = $signed(opa) >>> shamt;  // sign fill
      ALU_CMPULT: alu_out = {{(DATA_WIDTH - 1){1'b0}}, (opa < opb)};
      ALU_CMPEQ:  alu_out = {{(DATA_WIDTH - 1){1'b0}}, (opa == opb)};
      ALU_CMPULE: alu_out = {{(DATA_WIDTH - 1){1'b0}}, (opa <= opb)};
      ALU_CMPLT:  alu_out = {{(DATA_WIDTH - 1){1'b0}}, signed_lt(opa, opb)};
      ALU_CMPLE: begin
        alu_out = {{(DATA_WIDTH - 1){1'b0}}, (signed_lt(opa, opb) || (opa == opb))};
      end
      default:    alu_out = '0;  // mulq goes to the multiplier
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      alu_valid <= 1'b0;
    end else begin
      alu_valid <= accept;
    end
  end

  // payload only captured on an accepted op
  always_ff @(posedge clock) begin
    if (accept) begin
      alu_result.rob_tag <= issue.rob_tag;
      alu_result.result  <= alu_out;
    end
  end

endmodule

// File: src/exec_cluster.sv
`timescale 1ns/1ps

module exec_cluster import fu_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  logic          issue_valid,
  input  issue_packet_t issue,
  output logic          cdb_valid,
  output fu_result_t    cdb
);

  logic       alu_valid;
  fu_result_t alu_result;
  logic       mult_valid;
  fu_result_t mult_result;

  // both units see every issue and pick by func
  alu_unit i_alu_unit (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue       (issue),
    .alu_valid   (alu_valid),
    .alu_result  (alu_result)
  );

  mult_pipeline i_mult_pipeline (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue       (issue),
    .mult_valid  (mult_valid),
    .mult_result (mult_result)
  );

  result_merge i_result_merge (
    .clock       (clock),
    .reset       (reset),
    .alu_valid   (alu_valid),
    .alu_result  (alu_result),
    .mult_valid  (mult_valid),
    .mult_result (mult_result),
    .cdb_valid   (cdb_valid),
    .cdb         (cdb)
  );

endmodule

// File: src/fu_pkg.sv
package fu_pkg;

  localparam int DATA_WIDTH     = 64;
  localparam int LIT_WIDTH      = 8;
  localparam int ROB_TAG_WIDTH  = 5;   // 32 rob slots
  localparam int NUM_MULT_STAGE = 4;
  localparam int STAGE_BITS     = DATA_WIDTH / NUM_MULT_STAGE;
  localparam int MERGE_DEPTH    = NUM_MULT_STAGE;
  localparam int SHIFT_BITS     = 6;

  // merge queue pointer and occupancy widths
  localparam int MERGE_PTR_WIDTH = $clog2(MERGE_DEPTH);
  localparam int MERGE_CNT_WIDTH = $clog2(MERGE_DEPTH + 1);

  typedef enum logic [4:0] {
    ALU_ADDQ,
    ALU_SUBQ,
    ALU_AND,
    ALU_BIC,
    ALU_BIS,
    ALU_ORNOT,
    ALU_XOR,
    ALU_EQV,
    ALU_SRL,
    ALU_SLL,
    ALU_SRA,
    ALU_CMPULT,
    ALU_CMPEQ,
    ALU_CMPULE,
    ALU_CMPLT,
    ALU_CMPLE,
    ALU_MULQ    // only op routed to the multiplier
  } alu_func_t;

  typedef enum logic {
    OPB_IS_REGB,
    OPB_IS_LIT
  } opb_sel_t;

  typedef logic [ROB_TAG_WIDTH-1:0] rob_tag_t;

  typedef struct packed {
    alu_func_t             func;
    logic [DATA_WIDTH-1:0] opa;
    opb_sel_t              opb_sel;
    logic [DATA_WIDTH-1:0] opb_reg;
    logic [LIT_WIDTH-1:0]  lit;
    rob_tag_t              rob_tag;
  } issue_packet_t;

  typedef struct packed {
    rob_tag_t              rob_tag;
    logic [DATA_WIDTH-1:0] result;
  } fu_result_t;

  // literal is zero extended
  function automatic logic [DATA_WIDTH-1:0] operand_b(input issue_packet_t pkt);
    logic [DATA_WIDTH-1:0] value;
    if (pkt.opb_sel == OPB_IS_LIT) begin
      value = {{(DATA_WIDTH - LIT_WIDTH){1'b0}}, pkt.lit};
    end else begin
      value = pkt.opb_reg;
    end
    return value;
  endfunction

endpackage

// File: src/mult_pipeline.sv
`timescale 1ns/1ps

module mult_pipeline import fu_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  logic          issue_valid,
  input  issue_packet_t issue,
  output logic          mult_valid,
  output fu_result_t    mult_result
);

  // index 0 feeds the first stage, index NUM_MULT_STAGE is the last output
  logic [NUM_MULT_STAGE:0] stage_valid;
  rob_tag_t                stage_tag     [NUM_MULT_STAGE+1];
  logic [DATA_WIDTH-1:0]   stage_product [NUM_MULT_STAGE+1];
  logic [DATA_WIDTH-1:0]   stage_mplier  [NUM_MULT_STAGE+1];
  logic [DATA_WIDTH-1:0]   stage_mcand   [NUM_MULT_STAGE+1];

  assign stage_valid[0]   = issue_valid && (issue.func == ALU_MULQ);
  assign stage_tag[0]     = issue.rob_tag;
  assign stage_product[0] = '0;
  assign stage_mplier[0]  = issue.opa;
  assign stage_mcand[0]   = operand_b(issue);

  genvar i;
  generate
    for (i = 0; i < NUM_MULT_STAGE; i++) begin : g_stage
      mult_stage i_mult_stage (
        .clock       (clock),
        .reset       (reset),
        .in_valid    (stage_valid[i]),
        .in_tag      (stage_tag[i]),
        .in_product  (stage_product[i]),
        .in_mplier   (stage_mplier[i]),
        .in_mcand    (stage_mcand[i]),
        .out_valid   (stage_valid[i+1]),
        .out_tag     (stage_tag[i+1]),
        .out_product (stage_product[i+1]),
        .out_mplier  (stage_mplier[i+1]),
        .out_mcand   (stage_mcand[i+1])
      );
    end
  endgenerate

  assign mult_valid          = stage_valid[NUM_MULT_STAGE];
  assign mult_result.rob_tag = stage_tag[NUM_MULT_STAGE];
  assign mult_result.result  = stage_product[NUM_MULT_STAGE];

endmodule

// File: src/mult_stage.sv
`timescale 1ns/1ps

module mult_stage import fu_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  in_valid,
  input  rob_tag_t              in_tag,
  input  logic [DATA_WIDTH-1:0] in_product,
  input  logic [DATA_WIDTH-1:0] in_mplier,
  input  logic [DATA_WIDTH-1:0] in_mcand,
  output logic                  out_valid,
  output rob_tag_t              out_tag,
  output logic [DATA_WIDTH-1:0] out_product,
  output logic [DATA_WIDTH-1:0] out_mplier,
  output logic [DATA_WIDTH-1:0] out_mcand
);

  logic [STAGE_BITS-1:0] mplier_slice;
  logic [DATA_WIDTH-1:0] partial_product;
  logic [DATA_WIDTH-1:0] next_product;

  assign mplier_slice    = in_mplier[STAGE_BITS-1:0];
  assign partial_product = mplier_slice * in_mcand;  // low 64 bits only
  assign next_product    = in_product + partial_product;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // data follows the valid down the chain
  always_ff @(posedge clock) begin
    if (in_valid) begin
      out_tag     <= in_tag;
      out_product <= next_product;
      out_mplier  <= {{STAGE_BITS{1'b0}}, in_mplier[DATA_WIDTH-1:STAGE_BITS]};
      out_mcand   <= {in_mcand[DATA_WIDTH-STAGE_BITS-1:0], {STAGE_BITS{1'b0}}};
    end
  end

endmodule

// File: src/result_merge.sv
`timescale 1ns/1ps

module result_merge import fu_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       alu_valid,
  input  fu_result_t alu_result,
  input  logic       mult_valid,
  input  fu_result_t mult_result,
  output logic       cdb_valid,
  output fu_result_t cdb
);

  fu_result_t                 queue [MERGE_DEPTH];
  logic [MERGE_PTR_WIDTH-1:0] head;
  logic [MERGE_PTR_WIDTH-1:0] tail;
  logic [MERGE_CNT_WIDTH-1:0] count;
  logic                       queue_empty;
  logic                       push;
  logic                       pop;
  logic                       win_valid;
  fu_result_t                 winner;

  function automatic logic [MERGE_PTR_WIDTH-1:0] next_ptr(
      input logic [MERGE_PTR_WIDTH-1:0] ptr);
    logic [MERGE_PTR_WIDTH-1:0] nxt;
    if (ptr == MERGE_PTR_WIDTH'(MERGE_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign queue_empty = (count == '0);
  // alu result waits if the bus is taken by mult or older alu results
  assign push        = alu_valid && (mult_valid || !queue_empty);
  assign pop         = !mult_valid && !queue_empty;
  assign win_valid   = mult_valid || !queue_empty || alu_valid;

  always_comb begin
    if (mult_valid) begin
      winner = mult_result;
    end else if (!queue_empty) begin
      winner = queue[head];
    end else begin
      winner = alu_result;  // straight through when idle
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        tail <= next_ptr(tail);
      end
      if (pop) begin
        head <= next_ptr(head);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      queue[tail] <= alu_result;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= win_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (win_valid) begin
      cdb <= winner;
    end
  end

endmodule
